//--- design/bypass.sv
// operand bypass in front of the fixed-point alu
// one forwarding source only, the result register of the instruction ahead
// without forwarding the latched operands go to the alu unchanged

`timescale 1ns/100ps

module bypass
#(
	parameter bit ENABLE_FORWARDING = 1'b1
)
(
	// selects from forward_ctrl
	input  logic          fwd_a,
	input  logic          fwd_b,

	// register values latched at issue
	input  pu_pkg::data_t op_a,
	input  pu_pkg::data_t op_b,

	// result register
	input  pu_pkg::data_t res_data,

	// alu inputs
	output pu_pkg::data_t alu_a,
	output pu_pkg::data_t alu_b
);

	//--------------------------------------------------------------------------
	generate
	if (ENABLE_FORWARDING)
	begin : gen_forwarding

		// newest result wins over the value read at issue
		// a later load/store source would rank below fxdp
		always_comb
		begin
			// operand a
			if (fwd_a)
				alu_a = res_data;
			else
				alu_a = op_a;

			// operand b
			if (fwd_b)
				alu_b = res_data;
			else
				alu_b = op_b;
		end

	end : gen_forwarding
	//--------------------------------------------------------------------------
	else
	//--------------------------------------------------------------------------
	begin : gen_no_forwarding

		// selects are tied low upstream
		assign alu_a = op_a;
		assign alu_b = op_b;

	end : gen_no_forwarding
	//--------------------------------------------------------------------------
	endgenerate

endmodule : bypass

//--- design/exec_core.sv
// top of the fixed-point execute slice
// fixed latency of two cycles from issue_valid to res_valid
// without forwarding, dependent instructions must issue two slots apart
// no back-pressure; res_* is valid for one cycle only

`timescale 1ns/100ps

module exec_core
#(
	parameter bit ENABLE_FORWARDING = 1'b1
)
(
	input  logic             clk,
	input  logic             rst_n,

	// issue
	input  logic             issue_valid,
	input  pu_pkg::op_e      issue_op,
	input  pu_pkg::reg_idx_t issue_rd,
	input  pu_pkg::reg_idx_t issue_ra,
	input  pu_pkg::reg_idx_t issue_rb,
	input  pu_pkg::imm_t     issue_imm,

	// result
	output logic             res_valid,
	output pu_pkg::reg_idx_t res_rd,
	output pu_pkg::data_t    res_data
);

	import pu_pkg::*;

	// register file read data
	data_t    rd_data_a;
	data_t    rd_data_b;

	// operand stage
	logic     op_valid;
	op_e      op_kind;
	reg_idx_t op_ra;
	reg_idx_t op_rb;
	data_t    op_a;
	data_t    op_b;

	// bypass
	logic     fwd_a;
	logic     fwd_b;
	data_t    alu_a;
	data_t    alu_b;

	//--------------------------------------------------------------------------
	// producer, written back from the result register
	reg_file reg_file_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (issue_ra),
		.rd_addr_b (issue_rb),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (res_valid),
		.wr_addr   (res_rd),
		.wr_data   (res_data)
	);

	// pipeline and alu
	fxdp_alu fxdp_alu_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_rd    (issue_rd),
		.issue_ra    (issue_ra),
		.issue_rb    (issue_rb),
		.issue_imm   (issue_imm),
		.rd_data_a   (rd_data_a),
		.rd_data_b   (rd_data_b),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.op_valid    (op_valid),
		.op_kind     (op_kind),
		.op_ra       (op_ra),
		.op_rb       (op_rb),
		.op_a        (op_a),
		.op_b        (op_b),
		.res_valid   (res_valid),
		.res_rd      (res_rd),
		.res_data    (res_data)
	);

	// hazard detect, operand stage against result stage
	forward_ctrl #(.ENABLE_FORWARDING(ENABLE_FORWARDING)) forward_ctrl_inst (
		.op_valid  (op_valid),
		.op_kind   (op_kind),
		.op_ra     (op_ra),
		.op_rb     (op_rb),
		.res_valid (res_valid),
		.res_rd    (res_rd),
		.fwd_a     (fwd_a),
		.fwd_b     (fwd_b)
	);

	// operand muxes
	bypass #(.ENABLE_FORWARDING(ENABLE_FORWARDING)) bypass_inst (
		.fwd_a    (fwd_a),
		.fwd_b    (fwd_b),
		.op_a     (op_a),
		.op_b     (op_b),
		.res_data (res_data),
		.alu_a    (alu_a),
		.alu_b    (alu_b)
	);

endmodule : exec_core

//--- design/forward_ctrl.sv
// forward select logic between the result stage and the operand stage
// only distance-one hazards are seen here; distance two goes through
// write-through in the register file
// with forwarding disabled both selects stay low

`timescale 1ns/100ps

module forward_ctrl
#(
	parameter bit ENABLE_FORWARDING = 1'b1
)
(
	// operand stage
	input  logic             op_valid,
	input  pu_pkg::op_e      op_kind,
	input  pu_pkg::reg_idx_t op_ra,
	input  pu_pkg::reg_idx_t op_rb,

	// result stage
	input  logic             res_valid,
	input  pu_pkg::reg_idx_t res_rd,

	// selects towards the bypass muxes
	output logic             fwd_a,
	output logic             fwd_b
);

	import pu_pkg::*;

	//--------------------------------------------------------------------------
	generate
	if (ENABLE_FORWARDING)
	begin : gen_forwarding

		// both stages hold a live instruction
		logic pair_live;
		// li takes no register sources
		logic uses_src;

		assign pair_live = op_valid && res_valid;
		assign uses_src  = (op_kind != OP_LI);

		// raw between adjacent instructions, one select per operand
		always_comb
		begin
			fwd_a = pair_live && uses_src && (op_ra == res_rd);
			fwd_b = pair_live && uses_src && (op_rb == res_rd);
		end

	end : gen_forwarding
	//--------------------------------------------------------------------------
	else
	//--------------------------------------------------------------------------
	begin : gen_no_forwarding

		// issuer keeps dependent instructions two slots apart
		assign fwd_a = 1'b0;
		assign fwd_b = 1'b0;

	end : gen_no_forwarding
	//--------------------------------------------------------------------------
	endgenerate

endmodule : forward_ctrl

//--- design/fxdp_alu.sv
// fixed-point alu with operand stage and result register
// two-deep pipeline: issue in t, operand stage in t+1, result in t+2
// sums wrap at 32 bits, rotate uses the low five bits of operand b
// no stalls; a new instruction may enter every cycle

`timescale 1ns/100ps

module fxdp_alu
(
	input  logic             clk,
	input  logic             rst_n,

	// issue
	input  logic             issue_valid,
	input  pu_pkg::op_e      issue_op,
	input  pu_pkg::reg_idx_t issue_rd,
	input  pu_pkg::reg_idx_t issue_ra,
	input  pu_pkg::reg_idx_t issue_rb,
	input  pu_pkg::imm_t     issue_imm,

	// register file read data, same cycle as issue
	input  pu_pkg::data_t    rd_data_a,
	input  pu_pkg::data_t    rd_data_b,

	// operands after the bypass
	input  pu_pkg::data_t    alu_a,
	input  pu_pkg::data_t    alu_b,

	// operand stage
	output logic             op_valid,
	output pu_pkg::op_e      op_kind,
	output pu_pkg::reg_idx_t op_ra,
	output pu_pkg::reg_idx_t op_rb,
	output pu_pkg::data_t    op_a,
	output pu_pkg::data_t    op_b,

	// result stage
	output logic             res_valid,
	output pu_pkg::reg_idx_t res_rd,
	output pu_pkg::data_t    res_data
);

	import pu_pkg::*;

	// operand stage payload kept local
	reg_idx_t op_rd;
	imm_t     op_imm;

	// combinational result
	data_t                 alu_res;
	data_t                 imm_ext;
	logic [ROT_W-1:0]      rot_amt;
	logic [2*DATA_W-1:0]   rot_dbl;

	//--------------------------------------------------------------------------
	// operand stage
	//--------------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			op_valid <= 1'b0;
		else
			op_valid <= issue_valid;
	end

	// payload, qualified by op_valid
	always_ff @(posedge clk)
	begin
		op_kind <= issue_op;
		op_rd   <= issue_rd;
		op_ra   <= issue_ra;
		op_rb   <= issue_rb;
		op_imm  <= issue_imm;
		op_a    <= rd_data_a;
		op_b    <= rd_data_b;
	end

	//--------------------------------------------------------------------------
	// execute
	//--------------------------------------------------------------------------

	assign imm_ext = {{(DATA_W-IMM_W){op_imm[IMM_W-1]}}, op_imm};

	// rotate via doubled word, upper half holds the result
	assign rot_amt = alu_b[ROT_W-1:0];
	assign rot_dbl = {alu_a, alu_a} << rot_amt;

	always_comb
	begin
		case (op_kind)
			OP_LI:   alu_res = imm_ext;
			OP_ADD:  alu_res = alu_a + alu_b;
			OP_SUB:  alu_res = alu_a - alu_b;
			OP_AND:  alu_res = alu_a & alu_b;
			OP_OR:   alu_res = alu_a | alu_b;
			OP_XOR:  alu_res = alu_a ^ alu_b;
			OP_ROTL: alu_res = rot_dbl[2*DATA_W-1:DATA_W];
			default: alu_res = '0;
		endcase
	end

	//--------------------------------------------------------------------------
	// result stage
	//--------------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			res_valid <= 1'b0;
		else
			res_valid <= op_valid;
	end

	always_ff @(posedge clk)
	begin
		res_rd   <= op_rd;
		res_data <= alu_res;
	end

endmodule : fxdp_alu

//--- design/pu_pkg.sv
// shared types for the fixed-point execute slice
// widths are fixed here; the register file depth must match REG_IDX_W
// opcode encoding 3'd7 is unused and yields a zero result

package pu_pkg;

	//--------------------------------------------------------------------------
	// widths
	//--------------------------------------------------------------------------

	// machine word
	localparam int DATA_W    = 32;
	// register index, 16 gprs
	localparam int REG_IDX_W = 4;
	localparam int NUM_REGS  = 16;
	// immediate field of the issue word
	localparam int IMM_W     = 16;
	// rotate amount taken from low bits of operand b
	localparam int ROT_W     = 5;

	//--------------------------------------------------------------------------
	// vector types
	//--------------------------------------------------------------------------

	// register value or alu result
	typedef logic [DATA_W-1:0]    data_t;
	// gpr number
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	// raw immediate, sign-extended in the alu
	typedef logic [IMM_W-1:0]     imm_t;

	//--------------------------------------------------------------------------
	// opcodes
	//--------------------------------------------------------------------------

	// li ignores both source registers
	typedef enum logic [2:0] {
		OP_LI   = 3'd0,
		OP_ADD  = 3'd1,
		OP_SUB  = 3'd2,
		OP_AND  = 3'd3,
		OP_OR   = 3'd4,
		OP_XOR  = 3'd5,
		OP_ROTL = 3'd6
	} op_e;

endpackage : pu_pkg

//--- design/reg_file.sv
// 16 x 32 register file, one write port and two combinational read ports
// a read of the register being written in the same cycle returns wr_data,
// which covers the distance-two hazard of the execute slice
// all entries are cleared by reset

`timescale 1ns/100ps

module reg_file
(
	input  logic             clk,
	input  logic             rst_n,

	// read ports, addressed straight from issue
	input  pu_pkg::reg_idx_t rd_addr_a,
	input  pu_pkg::reg_idx_t rd_addr_b,
	output pu_pkg::data_t    rd_data_a,
	output pu_pkg::data_t    rd_data_b,

	// write port, fed by the result register
	input  logic             wr_en,
	input  pu_pkg::reg_idx_t wr_addr,
	input  pu_pkg::data_t    wr_data
);

	import pu_pkg::*;

	// storage
	data_t regs [NUM_REGS];

	// write-through hits
	logic hit_a;
	logic hit_b;

	//--------------------------------------------------------------------------
	// write port
	//--------------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr_en)
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	//--------------------------------------------------------------------------
	// read ports
	//--------------------------------------------------------------------------

	// same-cycle write to the addressed register
	assign hit_a = wr_en && (wr_addr == rd_addr_a);
	assign hit_b = wr_en && (wr_addr == rd_addr_b);

	// new data wins over the stored value
	always_comb
	begin
		rd_data_a = hit_a ? wr_data : regs[rd_addr_a];
		rd_data_b = hit_b ? wr_data : regs[rd_addr_b];
	end

endmodule : reg_file

//--- filelist.f
design/pu_pkg.sv
design/reg_file.sv
design/forward_ctrl.sv
design/bypass.sv
design/fxdp_alu.sv
design/exec_core.sv
verif/exec_core_checker.sv
verif/exec_core_tb.sv

//--- verif/exec_core_checker.sv
// concurrent checks on the execute slice, bound into exec_core
// latency checks assume no reset in the middle of a run
// fail_count is read by the testbench at the end of the run

`timescale 1ns/100ps

module exec_core_checker
(
	input logic             clk,
	input logic             rst_n,
	input logic             issue_valid,
	input pu_pkg::reg_idx_t issue_rd,
	input pu_pkg::reg_idx_t issue_ra,
	input pu_pkg::reg_idx_t issue_rb,
	input logic             res_valid,
	input logic             fwd_a,
	input logic             fwd_b,
	input pu_pkg::data_t    res_data
);

	// failed assertions so far
	int fail_count = 0;

	//--------------------------------------------------------------------------
	// strobe timing
	//--------------------------------------------------------------------------

	// every issue shows up two cycles later
	a_issue_to_res : assert property (@(posedge clk) disable iff (!rst_n)
		issue_valid |-> ##2 res_valid)
	else
	begin
		$error("res_valid missing two cycles after issue_valid");
		fail_count++;
	end

	// and no result without an issue
	a_res_from_issue : assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> $past(issue_valid, 2))
	else
	begin
		$error("res_valid without issue_valid two cycles earlier");
		fail_count++;
	end

	//--------------------------------------------------------------------------
	// forwarding and data
	//--------------------------------------------------------------------------

	// selects only for a back-to-back pair that really depends on the one ahead
	a_fwd_a_dep : assert property (@(posedge clk) disable iff (!rst_n)
		fwd_a |-> ($past(issue_valid, 1) && $past(issue_valid, 2)
			&& ($past(issue_ra, 1) == $past(issue_rd, 2))))
	else
	begin
		$error("fwd_a high without a dependent instruction one slot ahead");
		fail_count++;
	end

	a_fwd_b_dep : assert property (@(posedge clk) disable iff (!rst_n)
		fwd_b |-> ($past(issue_valid, 1) && $past(issue_valid, 2)
			&& ($past(issue_rb, 1) == $past(issue_rd, 2))))
	else
	begin
		$error("fwd_b high without a dependent instruction one slot ahead");
		fail_count++;
	end

	a_res_known : assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> !$isunknown(res_data))
	else
	begin
		$error("res_data has unknown bits while res_valid is high");
		fail_count++;
	end

endmodule : exec_core_checker

bind exec_core exec_core_checker checker_inst (
	.clk         (clk),
	.rst_n       (rst_n),
	.issue_valid (issue_valid),
	.issue_rd    (issue_rd),
	.issue_ra    (issue_ra),
	.issue_rb    (issue_rb),
	.res_valid   (res_valid),
	.fwd_a       (fwd_a),
	.fwd_b       (fwd_b),
	.res_data    (res_data)
);

//--- verif/exec_core_input.txt
// op_rd_ra_rb_imm_expected in hex, one instruction per line
// op: 0 li, 1 add, 2 sub, 3 and, 4 or, 5 xor, 6 rotl
1_1_0_0_0000_00000000  // add r1 r0 r0, reset value
0_2_0_0_8000_ffff8000  // li r2, sign-extended
0_3_0_0_1234_00001234  // li r3
1_4_3_3_0000_00002468  // add r4 r3 r3, bypass on a and b
2_5_4_2_0000_0000a468  // sub r5 r4 r2, bypass on a
0_6_0_0_ffff_ffffffff  // li r6
1_7_5_6_0000_0000a467  // add r7 r5 r6, write-through a, bypass b, wraps
0_8_0_0_0004_00000004  // li r8
6_9_2_8_0000_fff8000f  // rotl r9 r2 r8, by 4
5_a_9_4_0000_fff82467  // xor r10 r9 r4
3_b_a_3_0000_00000024  // and r11 r10 r3
4_c_b_2_0000_ffff8024  // or r12 r11 r2
2_d_1_6_0000_00000001  // sub r13 r1 r6, wraps
1_e_d_c_0000_ffff8025  // add r14 r13 r12, bypass a, write-through b
0_f_0_0_001f_0000001f  // li r15
6_1_d_f_0000_80000000  // rotl r1 r13 r15, by 31
5_2_1_e_0000_7fff8025  // xor r2 r1 r14
3_3_2_2_0000_7fff8025  // and r3 r2 r2
6_4_5_1_0000_0000a468  // rotl r4 r5 r1, by 0
1_6_4_3_0000_8000248d  // add r6 r4 r3, bypass a, write-through b
2_7_0_2_0000_80007fdb  // sub r7 r0 r2

//--- verif/exec_core_tb.sv
// testbench for the execute slice with forwarding enabled
// the program in verif/exec_core_input.txt runs twice, back to back and then
// with random idle gaps; it never writes r0 and writes every other register
// before reading it, so both passes expect the same data

`timescale 1ns/100ps

module exec_core_tb;

	import pu_pkg::*;

	// room in the program buffer
	localparam int MAX_INSTR = 64;

	logic     clk;
	logic     rst_n;
	logic     issue_valid;
	op_e      issue_op;
	reg_idx_t issue_rd;
	reg_idx_t issue_ra;
	reg_idx_t issue_rb;
	imm_t     issue_imm;
	logic     res_valid;
	reg_idx_t res_rd;
	data_t    res_data;

	// program words, op rd ra rb imm expected
	logic [63:0] prog [MAX_INSTR];

	int          num_instr;
	int          total_issues;
	int          cycle_limit;
	int          cycle_count;
	int          done_count;
	int          error_count;
	logic [31:0] rand_state;

	// expected results in issue order
	reg_idx_t    exp_rd_q [$];
	data_t       exp_data_q [$];

	exec_core #(.ENABLE_FORWARDING(1'b1)) exec_core_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_rd    (issue_rd),
		.issue_ra    (issue_ra),
		.issue_rb    (issue_rb),
		.issue_imm   (issue_imm),
		.res_valid   (res_valid),
		.res_rd      (res_rd),
		.res_data    (res_data)
	);

	always #5 clk = ~clk;

	//--------------------------------------------------------------------------
	// helpers
	//--------------------------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic check_data(input string name, input data_t expected,
		input data_t actual, output bit ok);
		ok = (actual === expected);
		if (!ok)
		begin
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_rd(input string name, input reg_idx_t expected,
		input reg_idx_t actual, output bit ok);
		ok = (actual === expected);
		if (!ok)
		begin
			$display("Mismatch at %0t: %s expected r%0d got r%0d", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic drive_idle();
		issue_valid = 1'b0;
		issue_op    = OP_LI;
		issue_rd    = '0;
		issue_ra    = '0;
		issue_rb    = '0;
		issue_imm   = '0;
	endtask

	// one issue slot, expected result queued at the same time
	task automatic drive_instr(input logic [63:0] word);
		issue_valid = 1'b1;
		issue_op    = op_e'(word[62:60]);
		issue_rd    = word[59:56];
		issue_ra    = word[55:52];
		issue_rb    = word[51:48];
		issue_imm   = word[47:32];
		exp_rd_q.push_back(word[59:56]);
		exp_data_q.push_back(word[31:0]);
	endtask

	// gaps of 0 to 2 idle cycles when with_gaps is set
	task automatic run_program(input bit with_gaps);
		int gap;
		for (int i = 0; i < num_instr; i++)
		begin
			@(negedge clk);
			drive_instr(prog[i]);
			if (with_gaps)
			begin
				rand_state = xorshift32(rand_state);
				gap = int'(rand_state % 3);
				repeat (gap)
				begin
					@(negedge clk);
					drive_idle();
				end
			end
		end
		@(negedge clk);
		drive_idle();
	endtask

	//--------------------------------------------------------------------------
	// result monitor, outputs sampled away from the rising edge
	//--------------------------------------------------------------------------

	always @(negedge clk)
	begin : result_monitor
		reg_idx_t exp_rd;
		data_t    exp_data;
		bit       rd_ok;
		bit       data_ok;
		if (rst_n && res_valid)
		begin
			if (exp_data_q.size() == 0)
			begin
				$display("%0t: result strobe for r%0d with no instruction outstanding",
					$time, res_rd);
				error_count++;
			end
			else
			begin
				exp_rd   = exp_rd_q.pop_front();
				exp_data = exp_data_q.pop_front();
				check_rd("res_rd", exp_rd, res_rd, rd_ok);
				check_data("res_data", exp_data, res_data, data_ok);
				$display("instr %0d: r%0d = %h %s", done_count, res_rd, res_data,
					(rd_ok && data_ok) ? "ok" : "wrong");
				done_count++;
			end
		end
	end

	// run limit in cycles, from the program length
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("timeout after %0d cycles, results stopped arriving, %0d outstanding",
				cycle_count, exp_data_q.size());
			$display("Checks failed");
			$finish;
		end
	end

	//--------------------------------------------------------------------------
	// main sequence
	//--------------------------------------------------------------------------

	initial
	begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		drive_idle();
		cycle_count = 0;
		done_count  = 0;
		error_count = 0;
		rand_state  = 32'd22444;

		$readmemh("verif/exec_core_input.txt", prog);
		num_instr = 0;
		while (num_instr < MAX_INSTR && !$isunknown(prog[num_instr]))
			num_instr++;
		if (num_instr == 0)
		begin
			$display("no instructions could be read from the input file");
			error_count++;
		end
		total_issues = 2 * num_instr;
		cycle_limit  = total_issues * 3 + 16 + 20;

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		run_program(1'b0);
		run_program(1'b1);

		// drain, then a few cycles to catch stray strobes
		while (exp_data_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);

		$display("%0d of %0d results, %0d errors, %0d assertion failures",
			done_count, total_issues, error_count, exec_core_inst.checker_inst.fail_count);
		if (error_count == 0 && exec_core_inst.checker_inst.fail_count == 0
			&& done_count == total_issues)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule : exec_core_tb
